/* Bender.yml */
package:
  name: cart_addr

sources:
  - verilog/cart_pkg.sv
  - verilog/snes_bus_sync.sv
  - verilog/address.sv
  - verilog/mem_req.sv
  - verilog/cart_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/cart_asserts.sv
      - verif/cart_tb.sv

/* src.f */
verilog/cart_pkg.sv
verilog/snes_bus_sync.sv
verilog/address.sv
verilog/mem_req.sv
verilog/cart_top.sv
verif/tb_clkgen.sv
verif/cart_asserts.sv
verif/cart_tb.sv

/* verif/cart_asserts.sv */
`timescale 1ns/1ps

module cart_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input logic [cart_pkg::ADDR_W-1:0]   snes_addr,
  input logic [cart_pkg::PA_W-1:0]     snes_pa,
  input logic                          snes_rd_n,
  input logic                          snes_wr_n,
  input logic                          snes_pard_n,
  input logic [cart_pkg::MAPPER_W-1:0] mapper,
  input logic [7:0]                    featurebits,
  input logic [cart_pkg::ADDR_W-1:0]   rom_mask,
  input logic [cart_pkg::ADDR_W-1:0]   saveram_mask,
  input logic                          mem_req,
  input logic [cart_pkg::ADDR_W-1:0]   mem_addr,
  input logic                          mem_we,
  input logic                          msu_sel,
  input logic                          srtc_sel,
  input logic                          dspx_sel,
  input logic                          dspx_a0,
  input logic                          r213f_sel,
  input logic                          cmd_rd_sel,
  input logic                          cmd_wr_sel
);
  import cart_pkg::*;

  // response is driven on the fifth edge, so the sixth tick samples it
  localparam int LAT = 6;

  int                fail_cnt = 0;
  logic              rd_q;
  logic              wr_q;
  logic              pard_q;
  logic              rd_fall;
  logic              wr_fall;
  logic              acc_fall;
  logic              pa_fall;
  logic [7:0]        bank;
  logic [7:0]        b7;
  logic [15:0]       off;
  logic              hi_sram;
  logic              lo_sram;
  logic              sram;
  logic              rom;
  logic [ADDR_W-1:0] exp_addr;
  logic              exp_msu;
  logic              exp_srtc;
  logic              exp_dspx;
  logic              exp_a0;
  logic              exp_cmd_wr;
  logic              exp_req;

  //////////////////////////////
  // strobe edges as seen on the sampling edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_q   <= 1'b1;
      wr_q   <= 1'b1;
      pard_q <= 1'b1;
    end else begin
      rd_q   <= snes_rd_n;
      wr_q   <= snes_wr_n;
      pard_q <= snes_pard_n;
    end
  end

  assign rd_fall  = rd_q & ~snes_rd_n;
  assign wr_fall  = wr_q & ~snes_wr_n;
  assign acc_fall = rd_fall | wr_fall;
  assign pa_fall  = pard_q & ~snes_pard_n;

  //////////////////////////////
  // reference map, written from the bank/offset windows
  always_comb begin
    bank    = snes_addr[23:16];
    off     = snes_addr[15:0];
    b7      = bank & 8'h7f;
    hi_sram = (b7 >= 8'h20) && (b7 <= 8'h3f) && (off >= 16'h6000) && (off < 16'h8000);
    lo_sram = (b7 >= 8'h70) && (b7 <= 8'h7d) && (off < 16'h8000);
    rom     = (b7 >= 8'h40) || (off >= 16'h8000);
    sram    = (mapper == MAP_LOROM) ? lo_sram : hi_sram;
    case (mapper)
      MAP_LOROM:
        exp_addr = lo_sram ? SAVERAM_BASE + (ADDR_W'({bank[4:0], off[14:0]}) & saveram_mask)
                           : ADDR_W'({bank[6:0], off[14:0]}) & rom_mask;
      // banks 40-7f sit 4 MB above banks c0-ff
      MAP_EXHIROM:
        exp_addr = hi_sram ? SAVERAM_BASE + (ADDR_W'({bank[4:0], off[12:0]}) & saveram_mask)
                           : (ADDR_W'(snes_addr[21:0]) | (bank[7] ? 24'h0 : 24'h400000))
                             & rom_mask;
      MAP_MENU:
        exp_addr = hi_sram ? MENU_SAVERAM_BASE + (ADDR_W'(off - 16'h6000) & saveram_mask)
                           : ({1'b0, snes_addr[22:0]} & rom_mask) + MENU_ROM_BASE;
      default:
        exp_addr = hi_sram ? SAVERAM_BASE + (ADDR_W'({bank[4:0], off[12:0]}) & saveram_mask)
                           : {1'b0, snes_addr[22:0]} & rom_mask;
    endcase
    // peripheral windows
    exp_msu  = featurebits[FEAT_MSU1] && !bank[6] && (off >= 16'h2000) && (off <= 16'h2007);
    exp_srtc = featurebits[FEAT_SRTC] && !bank[6] && (off >= 16'h2800) && (off <= 16'h2801);
    exp_dspx = 1'b0;
    exp_a0   = 1'b1;
    if (featurebits[FEAT_DSPX] && mapper == MAP_LOROM) begin
      exp_a0 = off[14];
      if (rom_mask[20])
        exp_dspx = (b7 >= 8'h60) && (b7 <= 8'h6f) && (off < 16'h8000);
      else
        exp_dspx = (b7 >= 8'h30) && (b7 <= 8'h3f) && (off >= 16'h8000);
    end else if (featurebits[FEAT_DSPX] && mapper == MAP_HIROM) begin
      exp_a0   = off[12];
      exp_dspx = (b7 <= 8'h0f) && (off >= 16'h6000) && (off < 16'h8000);
    end
    exp_cmd_wr = (snes_addr >= 24'hccccc0) && (snes_addr <= 24'hcccccf);
    // peripherals win, writes only land in saveram
    exp_req = !(exp_msu || exp_srtc || exp_dspx || exp_cmd_wr)
              && (wr_fall ? sram : (rom || sram));
  end

  //////////////////////////////
  // checks, one tick after the fifth edge past the sampling edge
  a_reset: assert property (@(posedge clk) !rst_n |=> !mem_req && !mem_we && !msu_sel
                            && !srtc_sel && !dspx_sel && !r213f_sel && !cmd_rd_sel && !cmd_wr_sel)
    else begin
      fail_cnt++;
      $error("outputs active after reset edge");
    end

  a_mem: assert property (@(posedge clk) disable iff (!rst_n)
    $past(acc_fall, LAT) |-> mem_req == $past(exp_req, LAT)
      && (!mem_req || (mem_addr == $past(exp_addr, LAT) && mem_we == $past(wr_fall, LAT))))
    else begin
      fail_cnt++;
      $error("memory request wrong, mem_addr %h", mem_addr);
    end

  a_sel: assert property (@(posedge clk) disable iff (!rst_n)
    $past(acc_fall, LAT) |-> msu_sel == $past(exp_msu, LAT)
      && srtc_sel == $past(exp_srtc, LAT)
      && dspx_sel == $past(exp_dspx, LAT) && cmd_wr_sel == $past(exp_cmd_wr, LAT)
      && (!dspx_sel || dspx_a0 == $past(exp_a0, LAT)))
    else begin
      fail_cnt++;
      $error("a-bus peripheral select wrong");
    end

  a_pa: assert property (@(posedge clk) disable iff (!rst_n)
    $past(pa_fall, LAT) |-> r213f_sel == $past(featurebits[FEAT_213F] && snes_pa == 8'h3f, LAT)
      && cmd_rd_sel == $past(snes_pa[7:4] == 4'hf, LAT))
    else begin
      fail_cnt++;
      $error("b-bus select wrong");
    end

  // nothing fires without an edge behind it
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(acc_fall, LAT) |-> !mem_req && !mem_we && !msu_sel && !srtc_sel && !dspx_sel
      && !cmd_wr_sel)
    else begin
      fail_cnt++;
      $error("a-bus output without access");
    end

  a_pa_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(pa_fall, LAT) |-> !r213f_sel && !cmd_rd_sel)
    else begin
      fail_cnt++;
      $error("b-bus select without access");
    end

endmodule

bind cart_top cart_asserts u_asserts (.*);

/* verif/cart_tb.sv */
`timescale 1ns/1ps

module cart_tb;
  import cart_pkg::*;

  localparam int  PERIOD  = 40;
  localparam int  ACC_CYC = 13;
  // accesses in all tests, plus reset and idle time
  localparam int  N_ACC   = 35;
  localparam time LIMIT   = (N_ACC * ACC_CYC + 40) * PERIOD * 3 / 2;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] snes_addr;
  logic [PA_W-1:0]   snes_pa;
  logic              snes_rd_n;
  logic              snes_wr_n;
  logic              snes_pard_n;
  logic [2:0]        mapper;
  logic [7:0]        featurebits;
  logic [ADDR_W-1:0] rom_mask;
  logic [ADDR_W-1:0] saveram_mask;
  logic              mem_req;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  logic              msu_sel;
  logic              srtc_sel;
  logic              dspx_sel;
  logic              dspx_a0;
  logic              r213f_sel;
  logic              cmd_rd_sel;
  logic              cmd_wr_sel;
  int                mem_cnt = 0;
  int                sel_cnt = 0;
  int                err_cnt = 0;

  tb_clkgen #(.PERIOD(PERIOD), .RST_CYC(10)) u_clkgen (.clk(clk), .rst_n(rst_n));

  cart_top dut0 (.*);

  // count responses away from the rising edge
  always @(negedge clk) begin
    mem_cnt += mem_req;
    sel_cnt += msu_sel + srtc_sel + dspx_sel + r213f_sel + cmd_rd_sel + cmd_wr_sel;
  end

  // one a-bus access, 8 cycles low then 4 idle
  task automatic access(input logic [ADDR_W-1:0] a, input logic wr);
    @(negedge clk);
    snes_addr = a;
    if (wr)
      snes_wr_n = 1'b0;
    else
      snes_rd_n = 1'b0;
    repeat (8) @(negedge clk);
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic pa_read(input logic [PA_W-1:0] pa);
    @(negedge clk);
    snes_pa     = pa;
    snes_pard_n = 1'b0;
    repeat (8) @(negedge clk);
    snes_pard_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic check_counts(input string name, input int exp_mem, input int exp_sel);
    if (mem_cnt != exp_mem) begin
      $display("CHECK FAILED %s mem_req count: expected %0d actual %0d", name, exp_mem, mem_cnt);
      err_cnt++;
    end
    if (sel_cnt != exp_sel) begin
      $display("CHECK FAILED %s select count: expected %0d actual %0d", name, exp_sel, sel_cnt);
      err_cnt++;
    end
    mem_cnt = 0;
    sel_cnt = 0;
  endtask

  function automatic logic [15:0] rnd(input int span);
    return 16'($urandom % span);
  endfunction

  initial begin
    #(LIMIT);
    $display("watchdog: simulation ran past its time limit");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(32'h67a6_ed7e));
    snes_addr    = '0;
    snes_pa      = '0;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    snes_pard_n  = 1'b1;
    mapper       = MAP_HIROM;
    featurebits  = 8'h00;
    rom_mask     = 24'h3fffff;
    saveram_mask = 24'h00ffff;
    @(posedge rst_n);
    repeat (8) @(negedge clk);
    check_counts("reset", 0, 0);

    //////////////////////////////
    // rom reads in each family
    mapper = MAP_LOROM;
    repeat (4) access({8'(rnd(64)), 16'h8000 | rnd(16'h8000)}, 1'b0);
    // 64 Mbit mask keeps bit 22 visible
    rom_mask = 24'h7fffff;
    mapper   = MAP_HIROM;
    repeat (4) access({8'hc0 | 8'(rnd(8)), rnd(16'hffff)}, 1'b0);
    mapper = MAP_EXHIROM;
    repeat (2) access({8'h40 | 8'(rnd(8)), rnd(16'hffff)}, 1'b0);
    repeat (2) access({8'hc0 | 8'(rnd(8)), rnd(16'hffff)}, 1'b0);
    rom_mask = 24'h3fffff;
    check_counts("rom", 12, 0);

    // saveram windows, both directions
    mapper = MAP_HIROM;
    access({8'h20 + 8'(rnd(32)), 16'h6000 + rnd(16'h2000)}, 1'b0);
    access({8'ha0 + 8'(rnd(32)), 16'h6000 + rnd(16'h2000)}, 1'b1);
    mapper = MAP_LOROM;
    access({8'h70 + 8'(rnd(14)), rnd(16'h8000)}, 1'b0);
    access({8'hf0 + 8'(rnd(14)), rnd(16'h8000)}, 1'b1);
    mapper = MAP_EXHIROM;
    access({8'h30, 16'h6000 + rnd(16'h2000)}, 1'b1);
    mapper = MAP_MENU;
    access({8'h20, 16'h6000 + rnd(16'h2000)}, 1'b0);
    access({8'h21, 16'h6000 + rnd(16'h2000)}, 1'b1);
    access({8'hc0 | 8'(rnd(8)), rnd(16'hffff)}, 1'b0);
    check_counts("saveram", 8, 0);

    // rom is read only
    mapper = MAP_HIROM;
    access({8'hc0 | 8'(rnd(8)), rnd(16'hffff)}, 1'b1);
    mapper = MAP_LOROM;
    access({8'(rnd(64)), 16'h8000 | rnd(16'h8000)}, 1'b1);
    check_counts("write_protect", 0, 0);

    //////////////////////////////
    // peripherals, first with features off
    mapper = MAP_HIROM;
    access({8'h00, 16'h2000 + rnd(8)}, 1'b0);
    pa_read(8'h3f);
    featurebits = 8'h1d;
    access({8'h00, 16'h2000 + rnd(8)}, 1'b0);
    // msu1 offsets in a rom bank are plain rom
    access({8'h40, 16'h2000 + rnd(8)}, 1'b0);
    access({8'h80, 16'h2800 + rnd(2)}, 1'b1);
    access({8'(rnd(16)), 16'h6000 + rnd(16'h2000)}, 1'b0);
    access({20'hccccc, 4'(rnd(16))}, 1'b1);
    mapper   = MAP_LOROM;
    rom_mask = 24'h0fffff;
    access({8'h30 + 8'(rnd(16)), 16'h8000 | rnd(16'h8000)}, 1'b0);
    pa_read(8'h3f);
    pa_read(8'hf0 + 8'(rnd(16)));
    pa_read(8'h3e);
    check_counts("peripheral", 1, 7);

    // read then write two cycles apart
    featurebits = 8'h00;
    rom_mask    = 24'h3fffff;
    mapper      = MAP_HIROM;
    @(negedge clk);
    snes_addr = {8'hc0 | 8'(rnd(8)), rnd(16'hffff)};
    snes_rd_n = 1'b0;
    repeat (2) @(negedge clk);
    snes_addr = {8'h20 + 8'(rnd(32)), 16'h6000 + rnd(16'h2000)};
    snes_wr_n = 1'b0;
    repeat (8) @(negedge clk);
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    repeat (4) @(negedge clk);
    check_counts("pipeline", 2, 0);

    $display("errors: %0d count checks, %0d assertions", err_cnt, dut0.u_asserts.fail_cnt);
    if (err_cnt == 0 && dut0.u_asserts.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD  = 40,
  parameter int RST_CYC = 10
) (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // release on a falling edge, like all other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* verilog/address.sv */
`timescale 1ns/1ps

module address (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cart_pkg::MAPPER_W-1:0] mapper,
  input  logic [7:0]                    featurebits,
  input  logic [cart_pkg::ADDR_W-1:0]   rom_mask,
  input  logic [cart_pkg::ADDR_W-1:0]   saveram_mask,
  input  logic                          cyc_strobe,
  input  logic                          cyc_write,
  input  logic [cart_pkg::ADDR_W-1:0]   cyc_addr,
  input  logic [cart_pkg::PA_W-1:0]     cyc_pa,
  input  logic                          pa_strobe,
  output logic                          dec_strobe,
  output logic                          dec_pa_strobe,
  output logic                          dec_write,
  output logic [cart_pkg::ADDR_W-1:0]   dec_rom_addr,
  output logic                          dec_is_rom,
  output logic                          dec_is_saveram,
  output logic                          dec_is_writable,
  output logic                          dec_msu,
  output logic                          dec_srtc,
  output logic                          dec_dspx,
  output logic                          dec_dspx_a0,
  output logic                          dec_r213f,
  output logic                          dec_cmd_rd,
  output logic                          dec_cmd_wr
);
  import cart_pkg::*;

  logic              hi_family;
  logic              is_saveram;
  logic              is_rom;
  logic [ADDR_W-1:0] sram_hi_off;
  logic [ADDR_W-1:0] sram_lo_off;
  logic [ADDR_W-1:0] sram_menu_off;
  logic [ADDR_W-1:0] rom_hi;
  logic [ADDR_W-1:0] rom_lo;
  logic [ADDR_W-1:0] rom_ex;
  logic [ADDR_W-1:0] map_addr;
  logic              msu_w;
  logic              srtc_w;
  logic              dspx_w;
  logic              dspx_a0_w;
  logic              r213f_w;
  logic              cmd_rd_w;
  logic              cmd_wr_w;

  //////////////////////////////
  // memory map

  // hirom, exhirom and menu share the sram window
  assign hi_family = (mapper == MAP_HIROM) || (mapper == MAP_EXHIROM)
                     || (mapper == MAP_MENU);

  // saveram_mask[0] clear means no saveram at all
  always_comb begin
    is_saveram = 1'b0;
    if (saveram_mask[0]) begin
      if (hi_family)
        // banks 20-3f / a0-bf, 6000-7fff
        is_saveram = ~cyc_addr[22] & cyc_addr[21] & ~cyc_addr[15] & (&cyc_addr[14:13]);
      else if (mapper == MAP_LOROM)
        // banks 70-7d / f0-fd, 0000-7fff
        is_saveram = (&cyc_addr[22:20]) & (cyc_addr[19:16] < 4'he) & ~cyc_addr[15];
    end
  end

  // upper half of each bank, or any bank 40-7f / c0-ff
  assign is_rom = cyc_addr[22] | cyc_addr[15];

  // sram offsets, bank bits on top
  assign sram_hi_off   = ADDR_W'({cyc_addr[20:16], cyc_addr[12:0]}) & saveram_mask;
  assign sram_lo_off   = ADDR_W'({cyc_addr[20:16], cyc_addr[14:0]}) & saveram_mask;
  assign sram_menu_off = ADDR_W'(cyc_addr[14:0] - 15'h6000) & saveram_mask;

  // rom views of the same address
  assign rom_hi = {1'b0, cyc_addr[22:0]} & rom_mask;
  // lorom drops a15
  assign rom_lo = {2'b00, cyc_addr[22:16], cyc_addr[14:0]} & rom_mask;
  // exhirom puts banks 40-7f above c0-ff
  assign rom_ex = {1'b0, ~cyc_addr[23], cyc_addr[21:0]} & rom_mask;

  always_comb begin
    case (mapper)
      MAP_HIROM:   map_addr = is_saveram ? SAVERAM_BASE + sram_hi_off : rom_hi;
      MAP_LOROM:   map_addr = is_saveram ? SAVERAM_BASE + sram_lo_off : rom_lo;
      MAP_EXHIROM: map_addr = is_saveram ? SAVERAM_BASE + sram_hi_off : rom_ex;
      // menu image sits in upper sram
      MAP_MENU:    map_addr = is_saveram ? MENU_SAVERAM_BASE + sram_menu_off
                                         : rom_hi + MENU_ROM_BASE;
      default:     map_addr = '0;
    endcase
  end

  //////////////////////////////
  // peripheral windows

  // msu1 at 2000-2007, system banks only
  assign msu_w = featurebits[FEAT_MSU1] & ~cyc_addr[22]
                 & ((cyc_addr[15:0] & 16'hfff8) == 16'h2000);
  // srtc data/ctrl at 2800-2801
  assign srtc_w = featurebits[FEAT_SRTC] & ~cyc_addr[22]
                  & ((cyc_addr[15:0] & 16'hfffe) == 16'h2800);

  // dsp lorom windows depend on rom size
  // large rom: 60-6f:0000-7fff, else 30-3f:8000-ffff
  // dsp hirom window: 00-0f:6000-7fff
  always_comb begin
    dspx_w    = 1'b0;
    dspx_a0_w = 1'b1;
    if (featurebits[FEAT_DSPX]) begin
      if (mapper == MAP_LOROM) begin
        dspx_a0_w = cyc_addr[14];
        if (rom_mask[20])
          dspx_w = cyc_addr[22] & cyc_addr[21] & ~cyc_addr[20] & ~cyc_addr[15];
        else
          dspx_w = ~cyc_addr[22] & cyc_addr[21] & cyc_addr[20] & cyc_addr[15];
      end else if (mapper == MAP_HIROM) begin
        dspx_a0_w = cyc_addr[12];
        dspx_w    = ~cyc_addr[22] & ~cyc_addr[21] & ~cyc_addr[20] & ~cyc_addr[15]
                    & (&cyc_addr[14:13]);
      end
    end
  end

  // b-bus decodes
  assign r213f_w  = featurebits[FEAT_213F] & (cyc_pa == 8'h3f);
  assign cmd_rd_w = (cyc_pa[7:4] == 4'hf);
  // snescmd write area cccc c0-cf
  assign cmd_wr_w = (cyc_addr[23:4] == 20'hccccc);

  //////////////////////////////
  // output register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_strobe    <= 1'b0;
      dec_pa_strobe <= 1'b0;
    end else begin
      dec_strobe    <= cyc_strobe;
      dec_pa_strobe <= pa_strobe;
    end
  end

  // decode results ride along with the strobes
  always_ff @(posedge clk) begin
    dec_write       <= cyc_write;
    dec_rom_addr    <= map_addr;
    dec_is_rom      <= is_rom;
    dec_is_saveram  <= is_saveram;
    // only saveram takes writes
    dec_is_writable <= is_saveram;
    dec_msu         <= msu_w;
    dec_srtc        <= srtc_w;
    dec_dspx        <= dspx_w;
    dec_dspx_a0     <= dspx_a0_w;
    dec_r213f       <= r213f_w;
    dec_cmd_rd      <= cmd_rd_w;
    dec_cmd_wr      <= cmd_wr_w;
  end

endmodule

/* verilog/cart_pkg.sv */
package cart_pkg;

  //////////////////////////////
  // bus widths

  // snes a-bus address
  localparam int ADDR_W   = 24;
  // snes b-bus (peripheral) address
  localparam int PA_W     = 8;
  localparam int MAPPER_W = 3;

  //////////////////////////////
  // mapper codes as set by the mcu

  localparam logic [MAPPER_W-1:0] MAP_HIROM   = 3'b000;
  localparam logic [MAPPER_W-1:0] MAP_LOROM   = 3'b001;
  localparam logic [MAPPER_W-1:0] MAP_EXHIROM = 3'b010;
  // menu rom lives in upper sram
  localparam logic [MAPPER_W-1:0] MAP_MENU    = 3'b111;

  // bit positions in featurebits
  localparam int FEAT_DSPX = 0;
  localparam int FEAT_SRTC = 2;
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  //////////////////////////////
  // sram base offsets

  localparam logic [ADDR_W-1:0] SAVERAM_BASE      = 24'hE00000;
  localparam logic [ADDR_W-1:0] MENU_SAVERAM_BASE = 24'hFF0000;
  localparam logic [ADDR_W-1:0] MENU_ROM_BASE     = 24'hC00000;

endpackage

/* verilog/cart_top.sv */
`timescale 1ns/1ps

module cart_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cart_pkg::ADDR_W-1:0]   snes_addr,
  input  logic [cart_pkg::PA_W-1:0]     snes_pa,
  input  logic                          snes_rd_n,
  input  logic                          snes_wr_n,
  input  logic                          snes_pard_n,
  input  logic [cart_pkg::MAPPER_W-1:0] mapper,
  input  logic [7:0]                    featurebits,
  input  logic [cart_pkg::ADDR_W-1:0]   rom_mask,
  input  logic [cart_pkg::ADDR_W-1:0]   saveram_mask,
  output logic                          mem_req,
  output logic [cart_pkg::ADDR_W-1:0]   mem_addr,
  output logic                          mem_we,
  output logic                          msu_sel,
  output logic                          srtc_sel,
  output logic                          dspx_sel,
  output logic                          dspx_a0,
  output logic                          r213f_sel,
  output logic                          cmd_rd_sel,
  output logic                          cmd_wr_sel
);
  import cart_pkg::*;

  //////////////////////////////
  // bus sync to decoder
  logic              cyc_strobe;
  logic              cyc_write;
  logic [ADDR_W-1:0] cyc_addr;
  logic [PA_W-1:0]   cyc_pa;
  logic              pa_strobe;

  // decoder to request stage
  logic              dec_strobe;
  logic              dec_pa_strobe;
  logic              dec_write;
  logic [ADDR_W-1:0] dec_rom_addr;
  logic              dec_is_rom;
  logic              dec_is_saveram;
  logic              dec_is_writable;
  logic              dec_msu;
  logic              dec_srtc;
  logic              dec_dspx;
  logic              dec_dspx_a0;
  logic              dec_r213f;
  logic              dec_cmd_rd;
  logic              dec_cmd_wr;

  // async snes strobes in, one pulse per access out
  snes_bus_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_bus_sync (
    .clk        (clk),
    .rst_n      (rst_n),
    .snes_addr  (snes_addr),
    .snes_pa    (snes_pa),
    .snes_rd_n  (snes_rd_n),
    .snes_wr_n  (snes_wr_n),
    .snes_pard_n(snes_pard_n),
    .cyc_strobe (cyc_strobe),
    .cyc_write  (cyc_write),
    .cyc_addr   (cyc_addr),
    .cyc_pa     (cyc_pa),
    .pa_strobe  (pa_strobe)
  );

  // mapper decode, one cycle
  address u_address (
    .clk            (clk),
    .rst_n          (rst_n),
    .mapper         (mapper),
    .featurebits    (featurebits),
    .rom_mask       (rom_mask),
    .saveram_mask   (saveram_mask),
    .cyc_strobe     (cyc_strobe),
    .cyc_write      (cyc_write),
    .cyc_addr       (cyc_addr),
    .cyc_pa         (cyc_pa),
    .pa_strobe      (pa_strobe),
    .dec_strobe     (dec_strobe),
    .dec_pa_strobe  (dec_pa_strobe),
    .dec_write      (dec_write),
    .dec_rom_addr   (dec_rom_addr),
    .dec_is_rom     (dec_is_rom),
    .dec_is_saveram (dec_is_saveram),
    .dec_is_writable(dec_is_writable),
    .dec_msu        (dec_msu),
    .dec_srtc       (dec_srtc),
    .dec_dspx       (dec_dspx),
    .dec_dspx_a0    (dec_dspx_a0),
    .dec_r213f      (dec_r213f),
    .dec_cmd_rd     (dec_cmd_rd),
    .dec_cmd_wr     (dec_cmd_wr)
  );

  // memory request or peripheral select
  mem_req u_mem_req (
    .clk            (clk),
    .rst_n          (rst_n),
    .dec_strobe     (dec_strobe),
    .dec_pa_strobe  (dec_pa_strobe),
    .dec_write      (dec_write),
    .dec_rom_addr   (dec_rom_addr),
    .dec_is_rom     (dec_is_rom),
    .dec_is_saveram (dec_is_saveram),
    .dec_is_writable(dec_is_writable),
    .dec_msu        (dec_msu),
    .dec_srtc       (dec_srtc),
    .dec_dspx       (dec_dspx),
    .dec_dspx_a0    (dec_dspx_a0),
    .dec_r213f      (dec_r213f),
    .dec_cmd_rd     (dec_cmd_rd),
    .dec_cmd_wr     (dec_cmd_wr),
    .mem_req        (mem_req),
    .mem_addr       (mem_addr),
    .mem_we         (mem_we),
    .msu_sel        (msu_sel),
    .srtc_sel       (srtc_sel),
    .dspx_sel       (dspx_sel),
    .dspx_a0        (dspx_a0),
    .r213f_sel      (r213f_sel),
    .cmd_rd_sel     (cmd_rd_sel),
    .cmd_wr_sel     (cmd_wr_sel)
  );

endmodule

/* verilog/mem_req.sv */
`timescale 1ns/1ps

module mem_req (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        dec_strobe,
  input  logic                        dec_pa_strobe,
  input  logic                        dec_write,
  input  logic [cart_pkg::ADDR_W-1:0] dec_rom_addr,
  input  logic                        dec_is_rom,
  input  logic                        dec_is_saveram,
  input  logic                        dec_is_writable,
  input  logic                        dec_msu,
  input  logic                        dec_srtc,
  input  logic                        dec_dspx,
  input  logic                        dec_dspx_a0,
  input  logic                        dec_r213f,
  input  logic                        dec_cmd_rd,
  input  logic                        dec_cmd_wr,
  output logic                        mem_req,
  output logic [cart_pkg::ADDR_W-1:0] mem_addr,
  output logic                        mem_we,
  output logic                        msu_sel,
  output logic                        srtc_sel,
  output logic                        dspx_sel,
  output logic                        dspx_a0,
  output logic                        r213f_sel,
  output logic                        cmd_rd_sel,
  output logic                        cmd_wr_sel
);

  logic periph_hit;
  logic mem_hit;
  logic mem_go;

  // a-bus peripherals claim the access before memory does
  assign periph_hit = dec_msu | dec_srtc | dec_dspx | dec_cmd_wr;
  // reads hit rom or sram, writes need writable space
  assign mem_hit = dec_write ? dec_is_writable : (dec_is_rom | dec_is_saveram);
  // rom writes fall out here with no request
  assign mem_go = dec_strobe & ~periph_hit & mem_hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_req    <= 1'b0;
      mem_we     <= 1'b0;
      msu_sel    <= 1'b0;
      srtc_sel   <= 1'b0;
      dspx_sel   <= 1'b0;
      r213f_sel  <= 1'b0;
      cmd_rd_sel <= 1'b0;
      cmd_wr_sel <= 1'b0;
    end else begin
      mem_req    <= mem_go;
      mem_we     <= mem_go & dec_write;
      msu_sel    <= dec_strobe & dec_msu;
      srtc_sel   <= dec_strobe & dec_srtc;
      dspx_sel   <= dec_strobe & dec_dspx;
      cmd_wr_sel <= dec_strobe & dec_cmd_wr;
      // b-bus reads only
      r213f_sel  <= dec_pa_strobe & dec_r213f;
      cmd_rd_sel <= dec_pa_strobe & dec_cmd_rd;
    end
  end

  // payload, qualified by the strobes above
  always_ff @(posedge clk) begin
    mem_addr <= dec_rom_addr;
    dspx_a0  <= dec_dspx_a0;
  end

endmodule

/* verilog/snes_bus_sync.sv */
`timescale 1ns/1ps

module snes_bus_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [cart_pkg::ADDR_W-1:0] snes_addr,
  input  logic [cart_pkg::PA_W-1:0]   snes_pa,
  input  logic                        snes_rd_n,
  input  logic                        snes_wr_n,
  input  logic                        snes_pard_n,
  output logic                        cyc_strobe,
  output logic                        cyc_write,
  output logic [cart_pkg::ADDR_W-1:0] cyc_addr,
  output logic [cart_pkg::PA_W-1:0]   cyc_pa,
  output logic                        pa_strobe
);
  import cart_pkg::*;

  // lane of each strobe in the bundled vectors
  localparam int S_RD   = 0;
  localparam int S_WR   = 1;
  localparam int S_PARD = 2;

  logic [SYNC_STAGES-1:0][2:0] strb_sync;
  // edge register, newest sample in [0]
  logic [1:0][2:0]             strb_edge;
  logic [2:0]                  strb_fall;
  // bus values follow the strobes so the capture sees the first sample
  logic [SYNC_STAGES:0][ADDR_W-1:0] addr_dly;
  logic [SYNC_STAGES:0][PA_W-1:0]   pa_dly;

  // high to low on the delayed strobes
  assign strb_fall = strb_edge[1] & ~strb_edge[0];

  //////////////////////////////
  // synchronizers, idle high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      strb_sync  <= '1;
      strb_edge  <= '1;
      cyc_strobe <= 1'b0;
      cyc_write  <= 1'b0;
      pa_strobe  <= 1'b0;
    end else begin
      strb_sync  <= {strb_sync[SYNC_STAGES-2:0], {snes_pard_n, snes_wr_n, snes_rd_n}};
      strb_edge  <= {strb_edge[0], strb_sync[SYNC_STAGES-1]};
      cyc_strobe <= strb_fall[S_RD] | strb_fall[S_WR];
      // write wins when both fall together
      cyc_write  <= strb_fall[S_WR];
      pa_strobe  <= strb_fall[S_PARD];
    end
  end

  // capture path
  always_ff @(posedge clk) begin
    addr_dly <= {addr_dly[SYNC_STAGES-1:0], snes_addr};
    pa_dly   <= {pa_dly[SYNC_STAGES-1:0], snes_pa};
    if (strb_fall[S_RD] | strb_fall[S_WR])
      cyc_addr <= addr_dly[SYNC_STAGES];
    if (strb_fall[S_PARD])
      cyc_pa <= pa_dly[SYNC_STAGES];
  end

endmodule
